/* verif/i2so_cases.txt */
// Records of four hex words: command, argument, left word, right word
// 1 push after idle gap, 2 push back to back (arg: full expected), 3 expect frame (arg: underrun)
// 4 align to a frame end, 5 expect arg silent frames, 6 idle outputs, 0 end
0006 0000 0000 0000
// Stream order, frame in flight at align time is silent
0004 0000 0000 0000
0001 0000 1234 ABCD
0001 0000 0F0F 7E81
0001 0000 CAFE BEEF
0003 0001 0000 0000
0003 0000 1234 ABCD
0003 0000 0F0F 7E81
0003 0000 CAFE BEEF
// Bit patterns for the I2S format
0004 0000 0000 0000
0001 0000 0000 FFFF
0001 0000 AAAA 5555
0001 0000 0001 8000
0003 0001 0000 0000
0003 0000 0000 FFFF
0003 0000 AAAA 5555
0003 0000 0001 8000
// Six pushes inside one frame, full after the fourth, last two dropped
0004 0000 0000 0000
0002 0000 1111 2222
0002 0000 3333 4444
0002 0000 5555 6666
0002 0001 7777 8888
0002 0001 9999 AAAA
0002 0001 BBBB CCCC
0003 0001 0000 0000
0003 0000 1111 2222
0003 0000 3333 4444
0003 0000 5555 6666
0003 0000 7777 8888
// FIFO drained, silent frames with underrun
0005 0003 0000 0000
0000 0000 0000 0000

/* filelist.f */
logic/i2so_pkg.sv
logic/sample_if.sv
logic/sck_sync.sv
logic/sample_fifo.sv
logic/i2so_serializer.sv
logic/i2so_top.sv
verif/i2so_properties.sv
verif/i2so_tb.sv

/* verif/i2so_tb.sv */
`timescale 1ns/1ps

module i2so_tb;

    // Command codes of the cases file
    localparam logic [15:0] CMD_END    = 16'h0000;
    localparam logic [15:0] CMD_PUSH   = 16'h0001;
    localparam logic [15:0] CMD_BURST  = 16'h0002;
    localparam logic [15:0] CMD_EXPECT = 16'h0003;
    localparam logic [15:0] CMD_ALIGN  = 16'h0004;
    localparam logic [15:0] CMD_SILENT = 16'h0005;
    localparam logic [15:0] CMD_IDLE   = 16'h0006;

    // 40 frames of 32 sck periods, 16 clk each, plus margin
    localparam int SCK_CLKS       = 16;
    localparam int TIMEOUT_CYCLES = 40 * i2so_pkg::FRAME_SLOTS * SCK_CLKS + 200;

    logic              clk;
    logic              rst_n;
    logic              sck;
    logic              push;
    i2so_pkg::stereo_t push_pair;
    logic              full;
    logic              sd;
    logic              ws;
    logic              underrun;

    // Four words per record
    logic [15:0] cases [256];

    // Frame decoder state
    i2so_pkg::word_t   acc;
    i2so_pkg::word_t   left_word;
    logic              left_under;
    logic              prev_ws;
    bit                have_left;
    int                run_len;
    int                ws_edges;
    int                under_total;
    int                under_mark;
    int                frames_done;
    i2so_pkg::stereo_t dec_pairs [$];
    logic              dec_under [$];

    int word_errs;
    int flag_errs;
    int fmt_errs;
    int other_errs;

    i2so_top #(
        .FIFO_DEPTH  (4),
        .SYNC_STAGES (2)
    ) i2so_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck       (sck),
        .push      (push),
        .push_pair (push_pair),
        .full      (full),
        .sd        (sd),
        .ws        (ws),
        .underrun  (underrun)
    );

    bind i2so_serializer i2so_properties i2so_properties_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .transition  (transition),
        .ws          (ws),
        .rts         (snk.rts),
        .rtr         (snk.rtr),
        .frame_start (snk.frame_start),
        .underrun    (underrun)
    );

    always #10 clk = ~clk;

    // Edges land on falling clk, away from the DUT edges
    always #160 sck = ~sck;

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_word(input string what, input i2so_pkg::word_t got,
                              input i2so_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // Starts and ends 2 ns after a rising clk
    task automatic send_pair(input int gap, input i2so_pkg::stereo_t pair,
                             input logic exp_full);
        if (gap > 0)
        begin
            repeat (gap) @(posedge clk);
            #2;
        end
        push      = 1'b1;
        push_pair = pair;
        @(posedge clk);
        #2;
        push = 1'b0;
        check_flag("full", full, exp_full);
    endtask

    // Wait for the next decoded frame end, drop everything seen so far
    task automatic align_to_frame();
        int start;
        start = frames_done;
        do
            @(posedge clk);
        while (frames_done == start);
        dec_pairs.delete();
        dec_under.delete();
        #2;
    endtask

    task automatic take_frame(input i2so_pkg::stereo_t exp, input logic exp_under);
        i2so_pkg::stereo_t got;
        logic              got_under;
        do
            @(posedge clk);
        while (dec_pairs.size() == 0);
        got       = dec_pairs.pop_front();
        got_under = dec_under.pop_front();
        #2;
        check_word("left word", got.lft, exp.lft);
        check_word("right word", got.rgt, exp.rgt);
        check_flag("underrun in frame", got_under, exp_under);
    endtask

    //////////////////////////////////////////////////
    // Frame decoder
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (underrun === 1'b1)
            under_total++;
    end

    // Mid slot, sd and ws settled long ago
    always @(negedge sck)
    begin
        if (rst_n)
        begin
            acc = {acc[i2so_pkg::WORD_BITS-2:0], sd};
            if (ws !== prev_ws)
            begin
                // First run after reset has no defined start
                if (ws_edges > 0 && run_len != i2so_pkg::WORD_BITS)
                begin
                    $display("Error at time %0t: ws held %b for %0d slots, expected %0d",
                             $time, prev_ws, run_len, i2so_pkg::WORD_BITS);
                    fmt_errs++;
                end
                ws_edges++;
                run_len = 1;
                if (ws)
                begin
                    // Slot 15, left LSB
                    left_word  = acc;
                    left_under = (under_total != under_mark);
                    if (under_total - under_mark > 1)
                    begin
                        $display("Error at time %0t: underrun pulsed %0d times in one frame",
                                 $time, under_total - under_mark);
                        fmt_errs++;
                    end
                    under_mark = under_total;
                    have_left  = 1'b1;
                end
                else if (have_left)
                begin
                    // Slot 31, right LSB closes the frame
                    dec_pairs.push_back({left_word, acc});
                    dec_under.push_back(left_under);
                    frames_done++;
                end
                prev_ws = ws;
            end
            else
                run_len++;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int                idx;
        int                seed;
        bit                running;
        logic [15:0]       cmd;
        logic [15:0]       arg;
        i2so_pkg::stereo_t pair;
        clk         = 1'b0;
        sck         = 1'b0;
        rst_n       = 1'b0;
        push        = 1'b0;
        push_pair   = '0;
        acc         = '0;
        prev_ws     = 1'b0;
        have_left   = 1'b0;
        run_len     = 0;
        ws_edges    = 0;
        under_total = 0;
        under_mark  = 0;
        frames_done = 0;
        word_errs   = 0;
        flag_errs   = 0;
        fmt_errs    = 0;
        other_errs  = 0;
        seed        = 40511;
        void'($urandom(seed));
        $readmemh("verif/i2so_cases.txt", cases);
        repeat (5) @(posedge clk);
        #2;
        rst_n   = 1'b1;
        idx     = 0;
        running = 1'b1;
        while (running)
        begin
            cmd      = cases[4*idx];
            arg      = cases[4*idx+1];
            pair.lft = cases[4*idx+2];
            pair.rgt = cases[4*idx+3];
            case (cmd)
                CMD_END:
                    running = 1'b0;
                CMD_IDLE:
                begin
                    check_flag("full", full, arg[0]);
                    check_flag("sd", sd, arg[0]);
                    check_flag("ws", ws, arg[0]);
                    check_flag("underrun", underrun, arg[0]);
                end
                CMD_PUSH:
                    send_pair(1 + ($urandom % 8), pair, arg[0]);
                CMD_BURST:
                    send_pair(0, pair, arg[0]);
                CMD_ALIGN:
                    align_to_frame();
                CMD_EXPECT:
                    take_frame(pair, arg[0]);
                CMD_SILENT:
                    repeat (arg) take_frame('0, 1'b1);
                default:
                begin
                    $display("Unknown command %h in record %0d of the cases file", cmd, idx);
                    other_errs++;
                    running = 1'b0;
                end
            endcase
            idx++;
        end
        $display("Errors: %0d word, %0d flag, %0d format, %0d other",
                 word_errs, flag_errs, fmt_errs, other_errs);
        if (word_errs + flag_errs + fmt_errs + other_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Run limit
    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: test did not finish within %0d clk cycles", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verif/i2so_properties.sv */
`timescale 1ns/1ps

module i2so_properties (
    input logic clk,
    input logic rst_n,
    input logic transition,
    input logic ws,
    input logic rts,
    input logic rtr,
    input logic frame_start,
    input logic underrun
);

    //////////////////////////////////////////////////
    // Serializer handshake and ws timing
    //////////////////////////////////////////////////

    // ws moves only on the edge after a transition strobe
    assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $past(transition))
        else $error("ws changed without a transition strobe");

    // Load and silent frame exclude each other
    assert property (@(posedge clk) disable iff (!rst_n)
        !(rtr && underrun))
        else $error("rtr and underrun in the same cycle");

    // Both only at a frame boundary
    assert property (@(posedge clk) disable iff (!rst_n)
        rtr |-> frame_start)
        else $error("rtr outside frame start");

    assert property (@(posedge clk) disable iff (!rst_n)
        underrun |-> frame_start)
        else $error("underrun outside frame start");

    // Never take a pair from an empty FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        rtr |-> rts)
        else $error("rtr while rts low");

endmodule

/* logic/i2so_top.sv */
`timescale 1ns/1ps

module i2so_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sck,
    input  logic              push,
    input  i2so_pkg::stereo_t push_pair,
    output logic              full,
    output logic              sd,
    output logic              ws,
    output logic              underrun
);

    //////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////

    // Rising sck edge in the clk domain
    logic transition;

    // FIFO to serializer path
    sample_if pair_if ();

    //////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////

    sck_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) sck_sync_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck        (sck),
        .transition (transition)
    );

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sample_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_pair (push_pair),
        .full      (full),
        .src       (pair_if.source)
    );

    i2so_serializer i2so_serializer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .transition (transition),
        .snk        (pair_if.sink),
        .sd         (sd),
        .ws         (ws),
        .underrun   (underrun)
    );

endmodule

/* logic/i2so_serializer.sv */
`timescale 1ns/1ps

module i2so_serializer (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   transition,
    sample_if.sink snk,
    output logic   sd,
    output logic   ws,
    output logic   underrun
);

    //////////////////////////////////////////////////
    // Slot positions
    //////////////////////////////////////////////////

    // Frame boundary, ws drops for the left word
    localparam i2so_pkg::slot_t LAST_SLOT =
        i2so_pkg::slot_t'(i2so_pkg::FRAME_SLOTS - 1);

    // ws rises one slot before the right word
    localparam i2so_pkg::slot_t RIGHT_WS_SLOT =
        i2so_pkg::slot_t'(i2so_pkg::WORD_BITS - 1);

    // Reset value, one transition before the first boundary
    localparam i2so_pkg::slot_t RESET_SLOT = LAST_SLOT - 1'b1;

    i2so_pkg::slot_t slot_q;
    i2so_pkg::slot_t slot_nxt;

    // Left word in the top half, shifted out MSB first
    logic [i2so_pkg::FRAME_SLOTS-1:0] shreg_q;

    // Pair to load, zeros when the FIFO is empty
    i2so_pkg::stereo_t load_pair;

    // Slot we are about to enter, wraps 31 to 0
    assign slot_nxt = slot_q + 1'b1;

    //////////////////////////////////////////////////
    // Frame start and handshake
    //////////////////////////////////////////////////

    // Entering slot 31 on this transition
    assign snk.frame_start = transition && (slot_nxt == LAST_SLOT);

    // Take the head pair if one is waiting
    assign snk.rtr = snk.frame_start && snk.rts;

    // Nothing waiting, send a silent frame
    assign underrun = snk.frame_start && !snk.rts;

    assign load_pair = snk.rts ? snk.pair : '0;

    //////////////////////////////////////////////////
    // Slot counter, ws and shift register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot_q  <= RESET_SLOT;
            ws      <= 1'b0;
            sd      <= 1'b0;
            shreg_q <= '0;
        end
        else if (transition)
        begin
            slot_q <= slot_nxt;

            // ws leads the data by one slot
            if (slot_nxt == LAST_SLOT)
                ws <= 1'b0;
            else if (slot_nxt == RIGHT_WS_SLOT)
                ws <= 1'b1;

            // At the boundary sd still gets the old right LSB
            sd <= shreg_q[i2so_pkg::FRAME_SLOTS-1];

            if (snk.frame_start)
                shreg_q <= load_pair;
            else
                shreg_q <= {shreg_q[i2so_pkg::FRAME_SLOTS-2:0], 1'b0};
        end
    end

endmodule

/* logic/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  i2so_pkg::stereo_t push_pair,
    output logic              full,
    sample_if.source          src
);

    // Count needs one bit more than the pointers
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    i2so_pkg::stereo_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Accepted push and pop for this cycle
    logic do_push;
    logic do_pop;

    // Drop the write when no room
    assign do_push = push && !full;

    // Serializer only asserts rtr while rts is high
    assign do_pop = src.rtr && src.rts;

    // New pair goes in at the tail
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr_q] <= push_pair;
    end

    // Pointers wrap by overflow of the power-of-two depth
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // Push and pop together leave count alone
            if (do_push && !do_pop)
                count_q <= count_q + 1'b1;
            else if (do_pop && !do_push)
                count_q <= count_q - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Status and head entry
    //////////////////////////////////////////////////

    assign full     = (count_q == CNT_FULL);
    assign src.rts  = (count_q != '0);
    assign src.pair = mem[rd_ptr_q];

endmodule

/* logic/sck_sync.sv */
`timescale 1ns/1ps

module sck_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    output logic transition
);

    //////////////////////////////////////////////////
    // Synchronizer chain
    //////////////////////////////////////////////////

    // Bit 0 takes raw sck, last bit is safe to use
    logic [SYNC_STAGES-1:0] sync_q;

    // Synchronized sck one clk later
    logic sck_dly_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q    <= '0;
            sck_dly_q <= 1'b0;
        end
        else
        begin
            sync_q    <= {sync_q[SYNC_STAGES-2:0], sck};
            sck_dly_q <= sync_q[SYNC_STAGES-1];
        end
    end

    //////////////////////////////////////////////////
    // Rising edge detect
    //////////////////////////////////////////////////

    // High now, low one clk ago, so one cycle wide
    assign transition = sync_q[SYNC_STAGES-1] && !sck_dly_q;

endmodule

/* logic/sample_if.sv */
`timescale 1ns/1ps

interface sample_if;

    // FIFO not empty, pair is valid
    logic rts;

    // Serializer took pair this cycle
    logic rtr;

    // Head entry of the FIFO
    i2so_pkg::stereo_t pair;

    // One-cycle pulse on every frame boundary
    logic frame_start;

    // FIFO side
    modport source (
        output rts,
        output pair,
        input  rtr
    );

    // Serializer side
    modport sink (
        input  rts,
        input  pair,
        output rtr,
        output frame_start
    );

endinterface

/* logic/i2so_pkg.sv */
package i2so_pkg;

    //////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////

    // Bits in one audio sample word
    localparam int WORD_BITS = 16;

    // Bit slots in one stereo frame, left then right
    localparam int FRAME_SLOTS = 32;

    //////////////////////////////////////////////////
    // Sample types
    //////////////////////////////////////////////////

    // One audio sample
    typedef logic [WORD_BITS-1:0] word_t;

    // Stereo pair, left word sits in the upper half
    typedef struct packed {
        word_t lft;
        word_t rgt;
    } stereo_t;

    // Slot counter, wraps at FRAME_SLOTS
    typedef logic [$clog2(FRAME_SLOTS)-1:0] slot_t;

endpackage
